// File: hw/mesosync_defs.svh
// link width, divider width and analyzer depth macros for the mesosync receiver
`ifndef MESOSYNC_DEFS_SVH
`define MESOSYNC_DEFS_SVH

// number of pins in the parallel link
`define MESO_WIDTH 8

// width of the divider and of every phase field
// a value of 0 means no division, 15 divides the core clock by 16
`define MESO_DIV_WIDTH 4

// samples recorded by one logic analyzer capture
// the analyzer buffer is sized to hold exactly one capture
`define MESO_LA_DEPTH 16

`endif

// File: hw/mesosync_pkg.sv
// package with per-line configuration, input mode, analyzer state and sample types
`include "mesosync_defs.svh"

package mesosync_pkg;

  // per-line receive setting
  // edge_sel picks the rising edge when 1 and the falling edge when 0
  // phase is the counter value in which the line is taken
  typedef struct packed {
    logic                       edge_sel;
    logic [`MESO_DIV_WIDTH-1:0] phase;
  } bit_cfg_t;

  // operating mode of the receive half
  typedef enum logic [1:0] {
    MODE_IDLE   = 2'd0,
    MODE_NORMAL = 2'd1,
    MODE_LA     = 2'd2
  } input_mode_t;

  // logic analyzer FSM states
  typedef enum logic [1:0] {
    LA_IDLE    = 2'd0,
    LA_ARMED   = 2'd1,
    LA_CAPTURE = 2'd2,
    LA_DRAIN   = 2'd3
  } la_state_t;

  // both edge samples of one line over one core cycle
  typedef struct packed {
    logic pos;
    logic neg;
  } la_sample_t;

endpackage

// File: hw/phase_counter.sv
// IO period counter that wraps after the programmed divider value
`include "mesosync_defs.svh"

module phase_counter (
  input  logic                       clk,
  input  logic                       channel_reset,
  input  logic [`MESO_DIV_WIDTH-1:0] divider_i,
  output logic [`MESO_DIV_WIDTH-1:0] count_o
);

  // the IO period is divider_i+1 core cycles long
  // count_o is 0 on the first cycle of every period
  logic wrap;

  // a greater-or-equal compare lets the counter wrap at once when the
  // divider is lowered below the current count, instead of running
  // through the whole counter range first
  assign wrap = (count_o >= divider_i);

  always_ff @(posedge clk) begin
    if (channel_reset) begin
      count_o <= '0;
    end else if (wrap) begin
      count_o <= '0;
    end else begin
      count_o <= count_o + 1'b1;
    end
  end

endmodule

// File: hw/ddr_sampler.sv
// double-edge pin sampler with both samples re-aligned to the rising edge
`include "mesosync_defs.svh"

module ddr_sampler (
  input  logic                   clk,
  input  logic                   channel_reset,
  input  logic [`MESO_WIDTH-1:0] pins_i,
  output logic [`MESO_WIDTH-1:0] pos_val_o,
  output logic [`MESO_WIDTH-1:0] neg_val_o
);

  // falling edge bank, it catches the pins in the middle of a cycle
  logic [`MESO_WIDTH-1:0] neg_q;

  // ------------------------------
  // falling edge capture
  // ------------------------------

  // this is the only register of the design on the falling edge
  always_ff @(negedge clk) begin
    neg_q <= pins_i;
  end

  // ------------------------------
  // rising edge banks
  // ------------------------------

  // the pins are taken directly on the rising edge, and the mid-cycle
  // sample is moved over to the rising edge on the same clock
  // both outputs therefore describe the cycle that just ended,
  // neg_val_o from its middle and pos_val_o from its closing edge
  always_ff @(posedge clk) begin
    if (channel_reset) begin
      pos_val_o <= '0;
      neg_val_o <= '0;
    end else begin
      pos_val_o <= pins_i;
      neg_val_o <= neg_q;
    end
  end

  // everything downstream of this point is single-edge logic

endmodule

// File: hw/phase_aligner.sv
// per-line edge and phase selection, word assembly and valid-only word strobe
`include "mesosync_defs.svh"

module phase_aligner
  import mesosync_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 channel_reset,
  input  input_mode_t                          mode_i,
  input  logic                                 enable_i,
  input  bit_cfg_t [`MESO_WIDTH-1:0]           bit_cfg_i,
  input  logic [`MESO_DIV_WIDTH-1:0]           count_i,
  input  logic [`MESO_WIDTH-1:0]               pos_val_i,
  input  logic [`MESO_WIDTH-1:0]               neg_val_i,
  output logic [`MESO_WIDTH-1:0]               data_o,
  output logic                                 valid_o
);

  logic [`MESO_WIDTH-1:0] sel_edge;
  logic [`MESO_WIDTH-1:0] phase_match;
  logic [`MESO_WIDTH-1:0] sampled_q;
  logic [`MESO_WIDTH-1:0] valid_n;
  logic [`MESO_WIDTH-1:0] valid_q;
  logic [`MESO_WIDTH-1:0] word;
  logic                   is_normal;
  logic                   word_done;
  logic                   word_done_q;

  assign is_normal = (mode_i == MODE_NORMAL);

  // ------------------------------
  // per-line selection
  // ------------------------------

  // each line picks its configured edge, and it matches exactly once
  // per period as long as its phase does not exceed the divider
  always_comb begin
    for (int i = 0; i < `MESO_WIDTH; i++) begin
      sel_edge[i]    = bit_cfg_i[i].edge_sel ? pos_val_i[i] : neg_val_i[i];
      phase_match[i] = (count_i == bit_cfg_i[i].phase);
    end
  end

  // the selected value is held for the rest of the period
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MESO_WIDTH; i++) begin
      if (is_normal && phase_match[i]) begin
        sampled_q[i] <= sel_edge[i];
      end
    end
  end

  // ------------------------------
  // word assembly
  // ------------------------------

  // a line's valid bit sets on its match and stays until the cycle after
  // the word is complete; a line whose phase is 0 may set again right in
  // that clearing cycle, which is why the match is or-ed in afterwards
  assign valid_n = {`MESO_WIDTH{is_normal}} &
                   ((valid_q & ~{`MESO_WIDTH{word_done_q}}) | phase_match);

  // the word completes on the match of the latest phase
  assign word_done = &valid_n;

  // lines that match in the completing cycle have not reached the latch
  // yet, so they are taken straight from the edge select
  always_comb begin
    for (int i = 0; i < `MESO_WIDTH; i++) begin
      word[i] = (phase_match[i] && word_done) ? sel_edge[i] : sampled_q[i];
    end
  end

  always_ff @(posedge clk) begin
    if (channel_reset) begin
      valid_q     <= '0;
      word_done_q <= 1'b0;
      valid_o     <= 1'b0;
      data_o      <= '0;
    end else begin
      valid_q     <= valid_n;
      word_done_q <= word_done;
      // one strobe per period, suppressed while the output is disabled
      valid_o     <= word_done && enable_i;
      if (word_done) begin
        data_o <= word;
      end
    end
  end

endmodule

// File: hw/la_controller.sv
// logic analyzer FSM that arms, waits for a period boundary, captures and drains
`include "mesosync_defs.svh"

module la_controller
  import mesosync_pkg::*;
(
  input  logic                              clk,
  input  logic                              channel_reset,
  input  input_mode_t                       mode_i,
  input  logic                              la_start_i,
  input  logic [$clog2(`MESO_WIDTH)-1:0]    line_sel_i,
  input  logic [`MESO_DIV_WIDTH-1:0]        count_i,
  input  logic [`MESO_WIDTH-1:0]            pos_val_i,
  input  logic [`MESO_WIDTH-1:0]            neg_val_i,
  input  logic                              buf_empty_i,
  output logic                              push_o,
  output la_sample_t                        push_data_o,
  output la_state_t                         state_o
);

  localparam int CNT_W = $clog2(`MESO_LA_DEPTH);

  la_state_t        state_n;
  logic [CNT_W-1:0] cnt_q;
  logic             last_sample;

  // the sampler adds one cycle, so pushing starts in the cycle after
  // count 0 and the first sample is the pin during the boundary cycle
  assign push_o              = (state_o == LA_CAPTURE);
  assign push_data_o.pos     = pos_val_i[line_sel_i];
  assign push_data_o.neg     = neg_val_i[line_sel_i];
  assign last_sample         = (cnt_q == CNT_W'(`MESO_LA_DEPTH - 1));

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin
    state_n = state_o;
    unique case (state_o)
      LA_IDLE:    if (la_start_i) state_n = LA_ARMED;
      LA_ARMED:   if (count_i == '0) state_n = LA_CAPTURE;
      LA_CAPTURE: if (last_sample) state_n = LA_DRAIN;
      LA_DRAIN:   if (buf_empty_i) state_n = LA_IDLE;
      default:    state_n = LA_IDLE;
    endcase
    // leaving analyzer mode aborts whatever is in progress
    if (mode_i != MODE_LA) begin
      state_n = LA_IDLE;
    end
  end

  // ------------------------------
  // state and sample counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (channel_reset) begin
      state_o <= LA_IDLE;
      cnt_q   <= '0;
    end else begin
      state_o <= state_n;
      // the counter only runs inside the capture window
      if (state_o == LA_CAPTURE) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

endmodule

// File: hw/la_buffer.sv
// analyzer sample FIFO with a registered ready/valid output stage
`include "mesosync_defs.svh"

module la_buffer
  import mesosync_pkg::*;
(
  input  logic       clk,
  input  logic       channel_reset,
  input  logic       push_i,
  input  la_sample_t push_data_i,
  output logic       empty_o,
  output la_sample_t la_data_o,
  output logic       la_valid_o,
  input  logic       la_ready_i
);

  localparam int AW = $clog2(`MESO_LA_DEPTH);

  // pointers carry one extra wrap bit to tell full from empty
  la_sample_t     mem [`MESO_LA_DEPTH];
  logic [AW:0]    wr_ptr;
  logic [AW:0]    rd_ptr;
  logic           stor_empty;
  logic           take;
  logic           load;

  assign stor_empty = (wr_ptr == rd_ptr);
  assign take       = la_valid_o && la_ready_i;

  // the output register refills whenever it is free or being taken
  assign load    = !stor_empty && (!la_valid_o || take);
  assign empty_o = stor_empty && !la_valid_o;

  // ------------------------------
  // storage
  // ------------------------------

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr[AW-1:0]] <= push_data_i;
    end
  end

  // ------------------------------
  // pointers and output stage
  // ------------------------------

  // the output register doubles as the relay stage toward a distant sink
  always_ff @(posedge clk) begin
    if (load) begin
      la_data_o <= mem[rd_ptr[AW-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (channel_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      la_valid_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load) begin
        rd_ptr     <= rd_ptr + 1'b1;
        la_valid_o <= 1'b1;
      end else if (take) begin
        la_valid_o <= 1'b0;
      end
    end
  end

endmodule

// File: hw/mesosync_input.sv
// receive half top level wiring the counter, sampler, aligner and analyzer
`include "mesosync_defs.svh"

module mesosync_input
  import mesosync_pkg::*;
(
  input  logic                              clk,
  input  logic                              channel_reset,
  input  logic [`MESO_WIDTH-1:0]            pins_i,
  input  input_mode_t                       mode_i,
  input  logic                              enable_i,
  input  logic [`MESO_DIV_WIDTH-1:0]        divider_i,
  input  bit_cfg_t [`MESO_WIDTH-1:0]        bit_cfg_i,
  input  logic [$clog2(`MESO_WIDTH)-1:0]    line_sel_i,
  input  logic                              la_start_i,
  output logic [`MESO_WIDTH-1:0]            data_o,
  output logic                              valid_o,
  output la_sample_t                        la_data_o,
  output logic                              la_valid_o,
  input  logic                              la_ready_i
);

  logic [`MESO_DIV_WIDTH-1:0] count;
  logic [`MESO_WIDTH-1:0]     pos_val;
  logic [`MESO_WIDTH-1:0]     neg_val;
  logic                       push;
  la_sample_t                 push_data;
  logic                       buf_empty;
  // analyzer state, watched by the bound property module
  la_state_t                  la_state;

  // ------------------------------
  // clocking and sampling
  // ------------------------------

  phase_counter i_phase_counter (
    .clk           (clk),
    .channel_reset (channel_reset),
    .divider_i     (divider_i),
    .count_o       (count)
  );

  ddr_sampler i_ddr_sampler (
    .clk           (clk),
    .channel_reset (channel_reset),
    .pins_i        (pins_i),
    .pos_val_o     (pos_val),
    .neg_val_o     (neg_val)
  );

  // ------------------------------
  // normal path and analyzer
  // ------------------------------

  phase_aligner i_phase_aligner (
    .clk (clk), .channel_reset (channel_reset), .mode_i (mode_i),
    .enable_i (enable_i), .bit_cfg_i (bit_cfg_i), .count_i (count),
    .pos_val_i (pos_val), .neg_val_i (neg_val), .data_o (data_o), .valid_o (valid_o)
  );

  la_controller i_la_controller (
    .clk (clk), .channel_reset (channel_reset), .mode_i (mode_i),
    .la_start_i (la_start_i), .line_sel_i (line_sel_i), .count_i (count),
    .pos_val_i (pos_val), .neg_val_i (neg_val), .buf_empty_i (buf_empty),
    .push_o (push), .push_data_o (push_data), .state_o (la_state)
  );

  la_buffer i_la_buffer (
    .clk (clk), .channel_reset (channel_reset), .push_i (push),
    .push_data_i (push_data), .empty_o (buf_empty), .la_data_o (la_data_o),
    .la_valid_o (la_valid_o), .la_ready_i (la_ready_i)
  );

endmodule

// File: testbench/mesosync_props.sv
// bound assertions on reset, analyzer output stability, word strobe mode and capture window
`include "mesosync_defs.svh"

module mesosync_props
  import mesosync_pkg::*;
(
  input logic        clk,
  input logic        channel_reset,
  input input_mode_t mode_i,
  input logic        valid_o,
  input la_sample_t  la_data_o,
  input logic        la_valid_o,
  input logic        la_ready_i,
  input la_state_t   la_state
);

  // number of assertion failures so far, read by the testbench at the end
  int error_count = 0;

  // both strobes are low in the cycle after a reset edge
  assert property (@(posedge clk) channel_reset |=> !valid_o && !la_valid_o)
    else begin
      $error("strobe high after reset");
      error_count++;
    end

  // a stalled analyzer sample must hold until it is taken
  assert property (@(posedge clk) disable iff (channel_reset)
    la_valid_o && !la_ready_i |=> la_valid_o && $stable(la_data_o))
    else begin
      $error("analyzer output changed under back-pressure");
      error_count++;
    end

  // the word strobe is registered, so it follows the mode one cycle later
  assert property (@(posedge clk) disable iff (channel_reset)
    mode_i != MODE_NORMAL |=> !valid_o)
    else begin
      $error("word strobe outside normal mode");
      error_count++;
    end

  // one capture window lasts exactly one buffer depth of cycles and then drains
  assert property (@(posedge clk) disable iff (channel_reset || mode_i != MODE_LA)
    $rose(la_state == LA_CAPTURE) |->
      ##(`MESO_LA_DEPTH - 1) (la_state == LA_CAPTURE) ##1 (la_state == LA_DRAIN))
    else begin
      $error("analyzer capture window has the wrong length");
      error_count++;
    end

endmodule

bind mesosync_input mesosync_props i_props (
  .clk (clk), .channel_reset (channel_reset), .mode_i (mode_i), .valid_o (valid_o),
  .la_data_o (la_data_o), .la_valid_o (la_valid_o), .la_ready_i (la_ready_i),
  .la_state (la_state)
);

// File: testbench/tb_mesosync_input.sv
// testbench for the mesosync receive half with directed tests, compare tasks and watchdog
`include "mesosync_defs.svh"

module tb_mesosync_input
  import mesosync_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int W = `MESO_WIDTH;
  localparam int DW = `MESO_DIV_WIDTH;
  localparam int LW = $clog2(`MESO_WIDTH);
  localparam int DEPTH = `MESO_LA_DEPTH;
  localparam int NUM_PATTERNS = 6;
  localparam logic [W-1:0] LA_PINS = 8'b0000_1000;
  // rough cycle budget per test, doubled for the watchdog
  localparam int WORD_CYCLES = NUM_PATTERNS * 4 * 6 + 40;
  localparam int LA_CYCLES = 3 * 100;
  localparam int WATCHDOG_CYCLES = 2 * (12 + WORD_CYCLES + 120 + LA_CYCLES);

  logic                  clk;
  logic                  channel_reset;
  logic [W-1:0]          pins_i;
  input_mode_t           mode_i;
  logic                  enable_i;
  logic [DW-1:0]         divider_i;
  bit_cfg_t [W-1:0]      bit_cfg_i;
  logic [LW-1:0]         line_sel_i;
  logic                  la_start_i;
  logic [W-1:0]          data_o;
  logic                  valid_o;
  la_sample_t            la_data_o;
  logic                  la_valid_o;
  logic                  la_ready_i;
  logic [31:0]           lcg_state;

  mesosync_input i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // helpers and compare tasks
  // ------------------------------

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task check_word(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
    if (act !== exp) report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  endtask

  task check_sample(input string name, input la_sample_t exp, input la_sample_t act);
    if (act !== exp) report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  endtask

  task check_count(input string name, input int exp, input int act);
    if (act != exp) report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
  endtask

  // configuration only changes while the mode is idle
  // phases are spread over the period and never exceed the divider
  task configure_link(input logic [DW-1:0] div);
    bit_cfg_t [W-1:0] cfg;
    @(posedge clk);
    mode_i <= MODE_IDLE;
    for (int i = 0; i < W; i++) begin
      cfg[i].edge_sel = 1'(i % 2);
      cfg[i].phase    = DW'((i * 5 + 2) % (int'(div) + 1));
    end
    @(posedge clk);
    divider_i <= div;
    bit_cfg_i <= cfg;
    @(posedge clk);
    mode_i   <= MODE_NORMAL;
    enable_i <= 1'b1;
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task run_reset_test();
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_flag("reset valid_o", 1'b0, valid_o);
      check_flag("reset la_valid_o", 1'b0, la_valid_o);
    end
    // fourth reset edge, then release
    @(posedge clk);
    channel_reset <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_flag("after reset valid_o", 1'b0, valid_o);
      check_flag("after reset la_valid_o", 1'b0, la_valid_o);
    end
  endtask

  // each pattern is held for four periods of six cycles, the last word must match
  task run_word_test();
    logic [31:0]  r;
    logic [W-1:0] pattern;
    logic [W-1:0] last_word;
    configure_link(DW'(5));
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      r = lcg_next();
      pattern = W'(r >> 8);
      @(posedge clk);
      pins_i <= pattern;
      last_word = 'x;
      repeat (4 * 6) begin
        @(negedge clk);
        if (valid_o) last_word = data_o;
      end
      check_word("word capture", pattern, last_word);
    end
  endtask

  task measure_spacing(input logic [DW-1:0] div);
    int gap;
    configure_link(div);
    @(negedge clk);
    while (!valid_o) @(negedge clk);
    repeat (4) begin
      gap = 0;
      do begin
        @(negedge clk);
        gap++;
      end while (!valid_o);
      check_count("pulse spacing", int'(div) + 1, gap);
    end
    // the strobe of the current cycle may still carry the old enable
    @(posedge clk);
    enable_i <= 1'b0;
    @(posedge clk);
    repeat (4 * (int'(div) + 1)) begin
      @(negedge clk);
      check_flag("valid_o while disabled", 1'b0, valid_o);
    end
    @(posedge clk);
    enable_i <= 1'b1;
  endtask

  // a transfer is counted at the negedge before the rising edge that performs it
  task run_capture(input string name, input logic [LW-1:0] line, input logic gaps);
    la_sample_t  exp;
    logic [31:0] r;
    int          n;
    int          extra;
    exp.pos = LA_PINS[line];
    exp.neg = LA_PINS[line];
    @(posedge clk);
    mode_i     <= MODE_LA;
    line_sel_i <= line;
    pins_i     <= LA_PINS;
    la_ready_i <= 1'b0;
    repeat (3) @(posedge clk);
    la_start_i <= 1'b1;
    @(posedge clk);
    la_start_i <= 1'b0;
    n = 0;
    while (n < DEPTH) begin
      r = lcg_next();
      la_ready_i <= gaps ? r[20] : 1'b1;
      @(negedge clk);
      if (la_valid_o && la_ready_i) begin
        check_sample(name, exp, la_data_o);
        n++;
      end
      @(posedge clk);
    end
    extra = 0;
    repeat (2 * DEPTH) begin
      la_ready_i <= 1'b1;
      @(negedge clk);
      if (la_valid_o) extra++;
      @(posedge clk);
    end
    check_count("samples after capture", 0, extra);
    la_ready_i <= 1'b0;
  endtask

  // ------------------------------
  // sequence and watchdog
  // ------------------------------

  initial begin
    lcg_state     = 32'd20;
    channel_reset = 1'b1;
    pins_i        = '0;
    mode_i        = MODE_IDLE;
    enable_i      = 1'b0;
    divider_i     = '0;
    bit_cfg_i     = '0;
    line_sel_i    = '0;
    la_start_i    = 1'b0;
    la_ready_i    = 1'b0;
    run_reset_test();
    run_word_test();
    measure_spacing(DW'(0));
    measure_spacing(DW'(3));
    run_capture("la capture high line", LW'(3), 1'b0);
    run_capture("la capture low line", LW'(5), 1'b0);
    run_capture("la capture back-pressure", LW'(3), 1'b1);
    if (i_dut.i_props.error_count != 0) begin
      report_failure("a bound assertion failed during the run");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired, the DUT never delivered an expected strobe or sample");
  end

endmodule

// File: tb.f
+incdir+hw
hw/mesosync_pkg.sv
hw/phase_counter.sv
hw/ddr_sampler.sv
hw/phase_aligner.sv
hw/la_controller.sv
hw/la_buffer.sv
hw/mesosync_input.sv
testbench/mesosync_props.sv
testbench/tb_mesosync_input.sv

// File: Bender.yml
package:
  name: mesosync_input

sources:
  - include_dirs:
      - hw
    files:
      - hw/mesosync_pkg.sv
      - hw/phase_counter.sv
      - hw/ddr_sampler.sv
      - hw/phase_aligner.sv
      - hw/la_controller.sv
      - hw/la_buffer.sv
      - hw/mesosync_input.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/mesosync_props.sv
      - testbench/tb_mesosync_input.sv
